// ==== rtl/axil_single_params.svh ====
/*
 * Bus geometry for the single-register AXI4-Lite bridge.
 * Include wherever a width or count is needed; the guard makes
 * repeated includes harmless.
 */
`ifndef AXIL_SINGLE_PARAMS_SVH
`define AXIL_SINGLE_PARAMS_SVH

// Bus data width in bits
`define AXS_DW		32

// Bus address width in bits
`define AXS_AW		32

// Number of one-word peripherals behind the bridge
`define AXS_NS		8

// log2 of the response FIFO depth
`define AXS_LGFLEN	2

// Word index width, byte offset bits dropped
`define AXS_IW		(`AXS_AW - 2)

`endif

// ==== rtl/axil_single_pkg.sv ====
/*
 * Request, strobe and response types shared by the bridge paths
 * and the peripheral bank. Modules import it in their header.
 */
`include "axil_single_params.svh"

package axil_single_pkg;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_DECERR = 2'b11;

	// Address channel request, word index only
	typedef struct packed {
		logic [`AXS_IW-1:0]	idx;
		logic [2:0]		prot;
	} aw_req_t;

	// Write data beat
	typedef struct packed {
		logic [`AXS_DW-1:0]	data;
		logic [`AXS_DW/8-1:0]	strb;
	} w_req_t;

	// Single-cycle write command toward the peripherals
	typedef struct packed {
		logic [`AXS_NS-1:0]	sel;
		logic [2:0]		prot;
		logic [`AXS_DW-1:0]	data;
		logic [`AXS_DW/8-1:0]	strb;
	} slv_wr_t;

	// Single-cycle read command toward the peripherals
	typedef struct packed {
		logic [`AXS_NS-1:0]	sel;
		logic [2:0]		prot;
	} slv_rd_t;

	// Responses from all peripherals, valid the cycle after a strobe
	typedef struct packed {
		logic [`AXS_NS-1:0][`AXS_DW-1:0]	data;
		logic [`AXS_NS-1:0][1:0]		wresp;
		logic [`AXS_NS-1:0][1:0]		rresp;
	} slv_rsp_t;

endpackage

// ==== rtl/skid_buffer.sv ====
/*
 * Valid/ready skid buffer. The upstream ready comes straight from a
 * register, a spare slot catches the beat that arrives while the
 * downstream stalls. OUTREG adds a registered output stage.
 */
`timescale 1ns/100ps

module skid_buffer #(
	parameter int DW = 8,
	parameter bit OUTREG = 1'b0
) (
	input  logic		S_AXI_ACLK,
	input  logic		S_AXI_ARESETN,
	input  logic		i_valid,
	output logic		o_ready,
	input  logic [DW-1:0]	i_data,
	output logic		o_valid,
	input  logic		i_ready,
	output logic [DW-1:0]	o_data
);

	// Spare slot
	logic		r_valid;
	logic [DW-1:0]	r_data;

	// Ready only depends on the spare slot being empty
	assign o_ready = !r_valid;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		// Beat accepted while the output is stalled
		else if (i_valid && o_ready && o_valid && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Spare data follows the input while the slot is free
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	generate
		if (OUTREG)
		begin : g_outreg
			logic		ro_valid;
			logic [DW-1:0]	ro_data;

			// Output stage loads when empty or when drained
			always_ff @(posedge S_AXI_ACLK)
			begin
				if (!S_AXI_ARESETN)
					ro_valid <= 1'b0;
				else if (!ro_valid || i_ready)
					ro_valid <= i_valid || r_valid;
			end

			// Spare slot has priority, it holds the older beat
			always_ff @(posedge S_AXI_ACLK)
			begin
				if (!ro_valid || i_ready)
					ro_data <= r_valid ? r_data : i_data;
			end

			assign o_valid = ro_valid;
			assign o_data  = ro_data;
		end
		else
		begin : g_comb
			// Pass-through unless the spare slot is busy
			assign o_valid = i_valid || r_valid;
			assign o_data  = r_valid ? r_data : i_data;
		end
	endgenerate

endmodule

// ==== rtl/resp_fifo.sv ====
/*
 * Synchronous FIFO for responses heading back to the master.
 * The head word is read combinationally and o_fill feeds the
 * reservation count of the owning path.
 */
`timescale 1ns/100ps

module resp_fifo #(
	parameter int BW = 2,
	parameter int LGFLEN = 2
) (
	input  logic		S_AXI_ACLK,
	input  logic		S_AXI_ARESETN,
	input  logic		i_wr,
	input  logic [BW-1:0]	i_data,
	input  logic		i_rd,
	output logic [BW-1:0]	o_data,
	output logic		o_empty,
	output logic [LGFLEN:0]	o_fill
);

	localparam int DEPTH = 1 << LGFLEN;

	// Response storage
	logic [BW-1:0]		mem [DEPTH];

	// Pointers carry one extra bit to tell full from empty
	logic [LGFLEN:0]	wr_ptr;
	logic [LGFLEN:0]	rd_ptr;
	logic			rd_en;

	// Never pop an empty FIFO
	assign rd_en = i_rd && !o_empty;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_wr)
			mem[wr_ptr[LGFLEN-1:0]] <= i_data;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assign o_fill  = wr_ptr - rd_ptr;
	assign o_empty = (wr_ptr == rd_ptr);
	assign o_data  = mem[rd_ptr[LGFLEN-1:0]];

endmodule

// ==== rtl/single_write_path.sv ====
/*
 * Write half of the bridge. Joins AW and W, turns the word index into
 * a one-hot write strobe, picks the peripheral's wresp a cycle later
 * and queues it toward B. Handshake to BVALID is three cycles.
 */
`timescale 1ns/100ps
`include "axil_single_params.svh"

module single_write_path
	import axil_single_pkg::*;
(
	input  logic		S_AXI_ACLK,
	input  logic		S_AXI_ARESETN,
	input  logic		i_awvalid,
	output logic		o_awready,
	input  aw_req_t		i_aw,
	input  logic		i_wvalid,
	output logic		o_wready,
	input  w_req_t		i_w,
	output logic		o_bvalid,
	input  logic		i_bready,
	output logic [1:0]	o_bresp,
	output slv_wr_t		o_wr,
	input  slv_rsp_t	i_rsp
);

	localparam int LGNS  = $clog2(`AXS_NS);
	localparam int DEPTH = 1 << `AXS_LGFLEN;
	localparam int PW    = `AXS_LGFLEN + 2;

	// Strobe stage payload keeps the full index for the range check
	typedef struct packed {
		logic [`AXS_IW-1:0]	idx;
		slv_wr_t		wr;
	} wr_stage_t;

	logic			aw_valid, w_valid, accept, room;
	aw_req_t		aw_s;
	w_req_t			w_s;
	wr_stage_t		stage_in, stage;
	logic			stg_valid;
	logic			cap_valid;
	logic [`AXS_IW-1:0]	idx_q;
	logic [1:0]		bresp_in;
	logic			b_empty;
	logic [`AXS_LGFLEN:0]	b_fill;
	logic [PW-1:0]		pending;

	//////////////////////////////
	// Request side
	//////////////////////////////

	skid_buffer #(.DW($bits(aw_req_t)), .OUTREG(1'b0)) u_awskid (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(i_awvalid), .o_ready(o_awready), .i_data(i_aw),
		.o_valid(aw_valid), .i_ready(accept), .o_data(aw_s)
	);

	skid_buffer #(.DW($bits(w_req_t)), .OUTREG(1'b0)) u_wskid (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(i_wvalid), .o_ready(o_wready), .i_data(i_w),
		.o_valid(w_valid), .i_ready(accept), .o_data(w_s)
	);

	// FIFO fill plus the two pipeline stages must leave one slot free
	assign pending = PW'(b_fill) + PW'(stg_valid) + PW'(cap_valid);
	assign room    = (pending < PW'(DEPTH));

	// Both halves present and a response slot reserved
	assign accept = aw_valid && w_valid && room;

	// One-hot decode with an empty select when out of range
	always_comb
	begin
		stage_in.idx     = aw_s.idx;
		stage_in.wr.sel  = '0;
		if (aw_s.idx < `AXS_NS)
			stage_in.wr.sel[aw_s.idx[LGNS-1:0]] = 1'b1;
		stage_in.wr.prot = aw_s.prot;
		stage_in.wr.data = w_s.data;
		stage_in.wr.strb = w_s.strb;
	end

	// Registered strobe stage that never stalls
	skid_buffer #(.DW($bits(wr_stage_t)), .OUTREG(1'b1)) u_wout (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(accept), .o_ready(), .i_data(stage_in),
		.o_valid(stg_valid), .i_ready(1'b1), .o_data(stage)
	);

	// Strobe lasts exactly the one cycle the stage is valid
	always_comb
	begin
		o_wr = stage.wr;
		if (!stg_valid)
			o_wr.sel = '0;
	end

	//////////////////////////////
	// Response side
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			cap_valid <= 1'b0;
		else
			cap_valid <= stg_valid;
	end

	// Index held for the capture cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		idx_q <= stage.idx;
	end

	assign bresp_in = (idx_q < `AXS_NS) ? i_rsp.wresp[idx_q[LGNS-1:0]] : RESP_DECERR;

	resp_fifo #(.BW(2), .LGFLEN(`AXS_LGFLEN)) u_bfifo (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_wr(cap_valid), .i_data(bresp_in),
		.i_rd(o_bvalid && i_bready), .o_data(o_bresp),
		.o_empty(b_empty), .o_fill(b_fill)
	);

	assign o_bvalid = !b_empty;

endmodule

// ==== rtl/single_read_path.sv ====
/*
 * Read half of the bridge. Same pipeline as the write path. The
 * capture cycle also takes the selected data word, or zero with
 * DECERR for an index past the last peripheral.
 */
`timescale 1ns/100ps
`include "axil_single_params.svh"

module single_read_path
	import axil_single_pkg::*;
(
	input  logic			S_AXI_ACLK,
	input  logic			S_AXI_ARESETN,
	input  logic			i_arvalid,
	output logic			o_arready,
	input  aw_req_t			i_ar,
	output logic			o_rvalid,
	input  logic			i_rready,
	output logic [`AXS_DW-1:0]	o_rdata,
	output logic [1:0]		o_rresp,
	output slv_rd_t			o_rd,
	input  slv_rsp_t		i_rsp
);

	localparam int LGNS  = $clog2(`AXS_NS);
	localparam int DEPTH = 1 << `AXS_LGFLEN;
	localparam int PW    = `AXS_LGFLEN + 2;

	typedef struct packed {
		logic [`AXS_IW-1:0]	idx;
		slv_rd_t		rd;
	} rd_stage_t;

	logic			ar_valid, accept, room;
	aw_req_t		ar_s;
	rd_stage_t		stage_in, stage;
	logic			stg_valid;
	logic			cap_valid;
	logic [`AXS_IW-1:0]	idx_q;
	logic [`AXS_DW+1:0]	r_in, r_out;
	logic			r_empty;
	logic [`AXS_LGFLEN:0]	r_fill;
	logic [PW-1:0]		pending;

	skid_buffer #(.DW($bits(aw_req_t)), .OUTREG(1'b0)) u_arskid (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(i_arvalid), .o_ready(o_arready), .i_data(i_ar),
		.o_valid(ar_valid), .i_ready(accept), .o_data(ar_s)
	);

	// Reserve a FIFO slot for everything still in the pipe
	assign pending = PW'(r_fill) + PW'(stg_valid) + PW'(cap_valid);
	assign room    = (pending < PW'(DEPTH));
	assign accept  = ar_valid && room;

	always_comb
	begin
		stage_in.idx     = ar_s.idx;
		stage_in.rd.sel  = '0;
		if (ar_s.idx < `AXS_NS)
			stage_in.rd.sel[ar_s.idx[LGNS-1:0]] = 1'b1;
		stage_in.rd.prot = ar_s.prot;
	end

	skid_buffer #(.DW($bits(rd_stage_t)), .OUTREG(1'b1)) u_rout (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(accept), .o_ready(), .i_data(stage_in),
		.o_valid(stg_valid), .i_ready(1'b1), .o_data(stage)
	);

	// Gate the select so it is a single-cycle pulse
	always_comb
	begin
		o_rd = stage.rd;
		if (!stg_valid)
			o_rd.sel = '0;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			cap_valid <= 1'b0;
		else
			cap_valid <= stg_valid;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		idx_q <= stage.idx;
	end

	// Data word in the high bits and response in the low bits
	always_comb
	begin
		if (idx_q < `AXS_NS)
			r_in = {i_rsp.data[idx_q[LGNS-1:0]], i_rsp.rresp[idx_q[LGNS-1:0]]};
		else
			r_in = {{`AXS_DW{1'b0}}, RESP_DECERR};
	end

	resp_fifo #(.BW(`AXS_DW + 2), .LGFLEN(`AXS_LGFLEN)) u_rfifo (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_wr(cap_valid), .i_data(r_in),
		.i_rd(o_rvalid && i_rready), .o_data(r_out),
		.o_empty(r_empty), .o_fill(r_fill)
	);

	assign o_rvalid = !r_empty;
	assign {o_rdata, o_rresp} = r_out;

endmodule

// ==== rtl/reg_slave_bank.sv ====
/*
 * Bank of one-word peripherals in their plainest form. A write strobe
 * updates the enabled bytes, a read strobe latches the word for the
 * next cycle. Responses are always OKAY.
 */
`timescale 1ns/100ps
`include "axil_single_params.svh"

module reg_slave_bank
	import axil_single_pkg::*;
(
	input  logic		S_AXI_ACLK,
	input  logic		S_AXI_ARESETN,
	input  slv_wr_t		i_wr,
	input  slv_rd_t		i_rd,
	output slv_rsp_t	o_rsp
);

	// One word per peripheral
	logic [`AXS_NS-1:0][`AXS_DW-1:0]	regs;

	// Read data, valid the cycle after the read strobe
	logic [`AXS_NS-1:0][`AXS_DW-1:0]	rd_data;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			regs <= '0;
		else
		begin
			for (int i = 0; i < `AXS_NS; i++)
			begin
				for (int b = 0; b < `AXS_DW/8; b++)
				begin
					// Byte lane update under strobe
					if (i_wr.sel[i] && i_wr.strb[b])
						regs[i][8*b +: 8] <= i_wr.data[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		for (int i = 0; i < `AXS_NS; i++)
		begin
			if (i_rd.sel[i])
				rd_data[i] <= regs[i];
		end
	end

	always_comb
	begin
		o_rsp.data = rd_data;
		for (int i = 0; i < `AXS_NS; i++)
		begin
			o_rsp.wresp[i] = RESP_OKAY;
			o_rsp.rresp[i] = RESP_OKAY;
		end
	end

endmodule

// ==== rtl/axil_single_top.sv ====
/*
 * AXI4-Lite slave port for a bank of one-word peripherals.
 * Wires the write path, read path and register bank together.
 */
`timescale 1ns/100ps
`include "axil_single_params.svh"

module axil_single_top
	import axil_single_pkg::*;
(
	input  logic			S_AXI_ACLK,
	input  logic			S_AXI_ARESETN,
	input  logic			i_awvalid,
	output logic			o_awready,
	input  logic [`AXS_AW-1:0]	i_awaddr,
	input  logic [2:0]		i_awprot,
	input  logic			i_wvalid,
	output logic			o_wready,
	input  logic [`AXS_DW-1:0]	i_wdata,
	input  logic [`AXS_DW/8-1:0]	i_wstrb,
	output logic			o_bvalid,
	input  logic			i_bready,
	output logic [1:0]		o_bresp,
	input  logic			i_arvalid,
	output logic			o_arready,
	input  logic [`AXS_AW-1:0]	i_araddr,
	input  logic [2:0]		i_arprot,
	output logic			o_rvalid,
	input  logic			i_rready,
	output logic [`AXS_DW-1:0]	o_rdata,
	output logic [1:0]		o_rresp
);

	aw_req_t	aw, ar;
	w_req_t		w;
	slv_wr_t	wr;
	slv_rd_t	rd;
	slv_rsp_t	rsp;

	// Word index only, byte offset bits are dropped
	assign aw = '{idx: i_awaddr[`AXS_AW-1:2], prot: i_awprot};
	assign ar = '{idx: i_araddr[`AXS_AW-1:2], prot: i_arprot};
	assign w  = '{data: i_wdata, strb: i_wstrb};

	single_write_path u_wr (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_awvalid, .o_awready, .i_aw(aw),
		.i_wvalid, .o_wready, .i_w(w),
		.o_bvalid, .i_bready, .o_bresp,
		.o_wr(wr), .i_rsp(rsp)
	);

	single_read_path u_rd (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_arvalid, .o_arready, .i_ar(ar),
		.o_rvalid, .i_rready, .o_rdata, .o_rresp,
		.o_rd(rd), .i_rsp(rsp)
	);

	reg_slave_bank u_bank (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_wr(wr), .i_rd(rd), .o_rsp(rsp)
	);

endmodule

// ==== bench/axil_single_tb.sv ====
/*
 * Testbench for the single-register AXI4-Lite bridge.
 * A random master drives AW, W and AR against a word model of the bank.
 * Every B and R response is checked in order, and the B latency is
 * checked during a back-to-back write burst.
 */
`timescale 1ns/100ps
`include "axil_single_params.svh"

module axil_single_tb;

	localparam int NTRANS     = 400;
	localparam int NBURST     = 8;
	localparam int NFIXED     = 20;
	localparam int MAX_CYCLES = (NTRANS + NBURST + NFIXED) * 20;
	localparam logic [1:0] OKAY   = 2'b00;
	localparam logic [1:0] DECERR = 2'b11;

	logic			S_AXI_ACLK;
	logic			S_AXI_ARESETN;
	logic			i_awvalid, o_awready;
	logic [`AXS_AW-1:0]	i_awaddr;
	logic [2:0]		i_awprot;
	logic			i_wvalid, o_wready;
	logic [`AXS_DW-1:0]	i_wdata;
	logic [`AXS_DW/8-1:0]	i_wstrb;
	logic			o_bvalid, i_bready;
	logic [1:0]		o_bresp;
	logic			i_arvalid, o_arready;
	logic [`AXS_AW-1:0]	i_araddr;
	logic [2:0]		i_arprot;
	logic			o_rvalid, i_rready;
	logic [`AXS_DW-1:0]	o_rdata;
	logic [1:0]		o_rresp;

	// Reference word per peripheral
	logic [`AXS_DW-1:0]	model [8];

	// Expected responses in issue order
	// A start cycle of -1 in exp_bcyc skips the latency check
	logic [1:0]		exp_bresp [$];
	int			exp_bcyc [$];
	logic [`AXS_DW+1:0]	exp_r [$];

	logic [31:0]	rng;
	int		cycles = 0;
	bit		burst;
	int		n_wr, n_rd, n_b, n_r;
	int		b_err, r_err, other_err;

	axil_single_top UUT (.*);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever
			#10 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	task automatic print_counts();
		$display("Summary: %0d B errors, %0d R errors, %0d other errors",
			b_err, r_err, other_err);
	endtask

	// Drives B and R ready for the coming edge and checks any handshake it will make
	task automatic serve_responses();
		logic [1:0]		eb;
		int			ec;
		logic [`AXS_DW+1:0]	er;
		logic [31:0]		r;
		r = xorshift32();
		// Ready low about a quarter of the time and held high in a burst
		i_bready = burst || (r[1:0] != 2'b00);
		i_rready = (r[3:2] != 2'b00);
		if (o_bvalid && i_bready)
		begin
			n_b++;
			if (exp_bresp.size() == 0)
			begin
				$display("%0t: B response arrived with no write outstanding", $time);
				other_err++;
			end
			else
			begin
				eb = exp_bresp.pop_front();
				ec = exp_bcyc.pop_front();
				if (o_bresp !== eb)
				begin
					$display("[ERROR] %0t o_bresp expected %0h actual %0h",
						$time, eb, o_bresp);
					b_err++;
				end
				if (ec >= 0 && cycles - ec != 3)
				begin
					$display("%0t: B came %0d cycles after its handshake instead of 3",
						$time, cycles - ec);
					other_err++;
				end
			end
		end
		if (o_rvalid && i_rready)
		begin
			n_r++;
			if (exp_r.size() == 0)
			begin
				$display("%0t: R response arrived with no read outstanding", $time);
				other_err++;
			end
			else
			begin
				er = exp_r.pop_front();
				if (o_rdata !== er[`AXS_DW+1:2])
				begin
					$display("[ERROR] %0t o_rdata expected %h actual %h",
						$time, er[`AXS_DW+1:2], o_rdata);
					r_err++;
				end
				if (o_rresp !== er[1:0])
				begin
					$display("[ERROR] %0t o_rresp expected %0h actual %0h",
						$time, er[1:0], o_rresp);
					r_err++;
				end
			end
		end
	endtask

	task automatic tick();
		@(negedge S_AXI_ACLK);
		serve_responses();
	endtask

	// One write with AW and W raised in independent cycles unless eager
	task automatic write_word(input int idx, input logic [`AXS_DW-1:0] data,
			input logic [`AXS_DW/8-1:0] strb, input bit eager);
		bit		aw_done, w_done, aw_go, w_go;
		int		hs;
		logic [31:0]	r;
		aw_done = 1'b0;
		w_done = 1'b0;
		hs = 0;
		r = xorshift32();
		i_awaddr = `AXS_AW'(idx) << 2;
		i_awprot = r[2:0];
		i_wdata = data;
		i_wstrb = strb;
		while (!aw_done || !w_done)
		begin
			r = xorshift32();
			if (!aw_done && (eager || r[0]))
				i_awvalid = 1'b1;
			if (!w_done && (eager || r[1]))
				i_wvalid = 1'b1;
			aw_go = i_awvalid && o_awready;
			w_go = i_wvalid && o_wready;
			aw_done = aw_done || aw_go;
			w_done = w_done || w_go;
			hs = cycles;
			tick();
			if (aw_go)
				i_awvalid = 1'b0;
			if (w_go)
				i_wvalid = 1'b0;
		end
		// Commit the enabled bytes once both handshakes are done
		if (idx < 8)
		begin
			for (int b = 0; b < `AXS_DW/8; b++)
			begin
				if (strb[b])
					model[idx][8*b +: 8] = data[8*b +: 8];
			end
			exp_bresp.push_back(OKAY);
		end
		else
			exp_bresp.push_back(DECERR);
		exp_bcyc.push_back(burst ? hs : -1);
		n_wr++;
	endtask

	task automatic read_word(input int idx, input bit eager);
		bit		go;
		logic [31:0]	r;
		go = 1'b0;
		r = xorshift32();
		i_araddr = `AXS_AW'(idx) << 2;
		i_arprot = r[2:0];
		while (!go)
		begin
			if (eager || r[3])
				i_arvalid = 1'b1;
			go = i_arvalid && o_arready;
			tick();
			r = xorshift32();
		end
		i_arvalid = 1'b0;
		// Out of range reads give zero data
		if (idx < 8)
			exp_r.push_back({model[idx], OKAY});
		else
			exp_r.push_back({{`AXS_DW{1'b0}}, DECERR});
		n_rd++;
	endtask

	// Waits until every outstanding response has come back
	task automatic drain();
		while (exp_bresp.size() != 0 || exp_r.size() != 0)
			tick();
	endtask

	//////////////////////////////
	// Timeout
	//////////////////////////////

	always @(posedge S_AXI_ACLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout, run stopped after %0d cycles", cycles);
			print_counts();
			$display("Errors found");
			$finish;
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin : main
		int		idx;
		bit		is_wr, last_wr;
		logic [31:0]	r, d;
		rng = 32'd11135;
		burst = 1'b0;
		{n_wr, n_rd, n_b, n_r} = '0;
		{b_err, r_err, other_err} = '0;
		for (int i = 0; i < 8; i++)
			model[i] = '0;
		S_AXI_ARESETN = 1'b0;
		{i_awvalid, i_wvalid, i_arvalid, i_bready, i_rready} = '0;
		i_awaddr = '0;
		i_awprot = '0;
		i_wdata = '0;
		i_wstrb = '0;
		i_araddr = '0;
		i_arprot = '0;
		repeat (10) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		tick();
		if (o_bvalid !== 1'b0)
		begin
			$display("[ERROR] %0t o_bvalid expected 0 actual %b", $time, o_bvalid);
			b_err++;
		end
		if (o_rvalid !== 1'b0)
		begin
			$display("[ERROR] %0t o_rvalid expected 0 actual %b", $time, o_rvalid);
			r_err++;
		end
		// Request channels are ready straight out of reset
		if (o_awready !== 1'b1)
		begin
			$display("[ERROR] %0t o_awready expected 1 actual %b", $time, o_awready);
			other_err++;
		end
		if (o_wready !== 1'b1)
		begin
			$display("[ERROR] %0t o_wready expected 1 actual %b", $time, o_wready);
			other_err++;
		end
		if (o_arready !== 1'b1)
		begin
			$display("[ERROR] %0t o_arready expected 1 actual %b", $time, o_arready);
			other_err++;
		end
		// Bank comes out of reset as all zero
		for (int i = 0; i < 8; i++)
			read_word(i, 1'b1);
		drain();
		// Partial write then read back
		write_word(3, 32'ha5a5_5a5a, 4'b0101, 1'b1);
		drain();
		read_word(3, 1'b1);
		drain();
		// Random mix drained on every change of direction so that order is defined
		last_wr = 1'b0;
		for (int n = 0; n < NTRANS; n++)
		begin
			r = xorshift32();
			is_wr = r[0];
			idx = int'(r[31:8] % 10);
			if (is_wr != last_wr)
				drain();
			last_wr = is_wr;
			if (is_wr)
			begin
				d = xorshift32();
				write_word(idx, d, r[7:4], 1'b0);
			end
			else
				read_word(idx, 1'b0);
		end
		drain();
		// Back-to-back writes with B ready held high
		burst = 1'b1;
		for (int k = 0; k < NBURST; k++)
		begin
			d = xorshift32();
			write_word(k, d, 4'hf, 1'b1);
		end
		drain();
		burst = 1'b0;
		for (int i = 0; i < 10; i++)
			read_word(i, 1'b1);
		drain();
		// Idle cycles catch any response beyond the last request
		repeat (8)
			tick();
		if (n_b != n_wr || n_r != n_rd)
		begin
			$display("Response counts do not match: %0d writes, %0d B, %0d reads, %0d R",
				n_wr, n_b, n_rd, n_r);
			other_err++;
		end
		print_counts();
		if (b_err + r_err + other_err == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/axil_single_pkg.sv
rtl/skid_buffer.sv
rtl/resp_fifo.sv
rtl/single_write_path.sv
rtl/single_read_path.sv
rtl/reg_slave_bank.sv
rtl/axil_single_top.sv
bench/axil_single_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the bridge testbench with Verilator, runs it and checks the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module axil_single_tb \
	-f vlog.f --Mdir obj_dir -o axil_single_sim

./obj_dir/axil_single_sim | tee sim.log

if grep -q "Errors found" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"
